/* Bender.yml */
package:
  name: riscv_hart

export_include_dirs:
  - include

sources:
  - design/hart_pkg.sv
  - design/hart_regfile.sv
  - design/hart_core.sv
  - design/port_switch.sv
  - design/riscv_hart_top.sv
  - target: test
    files:
      - tests/tb_mem_model.sv
      - tests/tb_riscv_hart_top.sv

/* design/hart_core.sv */
`include "hart_macros.svh"

module hart_core (
	input  logic                  clock_i,
	input  logic                  rst_n_i,

	// instruction fetch
	output logic                  inst_req_o,
	output logic [`HART_XLEN-1:0] inst_addr_o,
	input  logic [`HART_XLEN-1:0] inst_data_i,
	input  logic                  inst_done_i,

	// data references
	output logic                  data_req_o,
	output hart_pkg::mem_req_t    data_req_s_o,
	input  logic [`HART_XLEN-1:0] data_rdata_i,
	input  logic                  data_done_i,

	// status
	output logic [`HART_XLEN-1:0] pc_o,
	output logic [`HART_XLEN-1:0] inst_word_o,
	output logic [3:0]            exception_o
);

	typedef enum logic [2:0] {
		FETCH,
		FWAIT,
		EXEC,
		MWAIT,
		WB,
		HALT
	} state_e;

	// control state
	state_e                state_q;
	logic [`HART_XLEN-1:0] pc_q;
	logic                  inst_req_q;
	logic                  data_req_q;
	logic [3:0]            exc_q;

	// payload
	logic [`HART_XLEN-1:0] ir_q;
	logic [`HART_XLEN-1:0] wb_data_q;
	logic [`HART_XLEN-1:0] next_pc_q;
	hart_pkg::mem_req_t    data_req_s_q;

	// decode
	hart_pkg::opcode_e     opcode;
	logic [`HART_XLEN-1:0] imm_i;
	logic [`HART_XLEN-1:0] imm_s;
	logic [`HART_XLEN-1:0] imm_b;
	logic [`HART_XLEN-1:0] imm_u;
	logic [`HART_XLEN-1:0] rs1_data;
	logic [`HART_XLEN-1:0] rs2_data;
	logic [`HART_XLEN-1:0] op_b;
	logic [`HART_XLEN-1:0] sum;
	logic [`HART_XLEN-1:0] exec_result;
	logic [`HART_XLEN-1:0] next_pc;
	logic                  writes_rd;
	logic                  is_mem;
	logic                  is_store;
	logic                  illegal;
	logic                  rf_we;

	// --------------------
	// decode
	// --------------------

	assign opcode = hart_pkg::opcode_e'(ir_q[6:0]);

	// immediate formats
	assign imm_i = {{20{ir_q[31]}}, ir_q[31:20]};
	assign imm_s = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
	assign imm_b = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
	assign imm_u = {ir_q[31:12], 12'b0};

	// second adder operand
	always_comb begin
		case (opcode)
			hart_pkg::OP_REG:   op_b = rs2_data;
			hart_pkg::OP_STORE: op_b = imm_s;
			default:            op_b = imm_i;
		endcase
	end

	// shared adder, alu result and effective address
	assign sum = rs1_data + op_b;

	// per-opcode controls
	always_comb begin
		writes_rd   = 1'b0;
		is_mem      = 1'b0;
		is_store    = 1'b0;
		illegal     = 1'b0;
		exec_result = sum;
		next_pc     = pc_q + 32'd4;
		case (opcode)
			hart_pkg::OP_LUI: begin
				writes_rd   = 1'b1;
				exec_result = imm_u;
			end
			hart_pkg::OP_IMM,
			hart_pkg::OP_REG: begin
				writes_rd = 1'b1;
			end
			hart_pkg::OP_LOAD: begin
				writes_rd = 1'b1;
				is_mem    = 1'b1;
			end
			hart_pkg::OP_STORE: begin
				is_mem   = 1'b1;
				is_store = 1'b1;
			end
			hart_pkg::OP_BRANCH: begin
				// beq only, taken on equal
				if (rs1_data == rs2_data) begin
					next_pc = pc_q + imm_b;
				end
			end
			default: begin
				illegal = 1'b1;
			end
		endcase
	end

	// --------------------
	// control FSM
	// --------------------

	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			state_q    <= FETCH;
			pc_q       <= `HART_RESET_PC;
			inst_req_q <= 1'b0;
			data_req_q <= 1'b0;
			exc_q      <= '0;
		end else begin
			// strobes last one cycle
			inst_req_q <= 1'b0;
			data_req_q <= 1'b0;
			case (state_q)
				FETCH: begin
					// first launch out of reset
					inst_req_q <= 1'b1;
					state_q    <= FWAIT;
				end
				FWAIT: begin
					if (inst_done_i) begin
						state_q <= EXEC;
					end
				end
				EXEC: begin
					if (illegal) begin
						exc_q[hart_pkg::EXC_ILLEGAL] <= 1'b1;
						state_q                      <= HALT;
					end else if (is_mem) begin
						data_req_q <= 1'b1;
						state_q    <= MWAIT;
					end else begin
						state_q <= WB;
					end
				end
				MWAIT: begin
					if (data_done_i) begin
						state_q <= WB;
					end
				end
				WB: begin
					// commit pc, next fetch strobe goes out with it
					pc_q       <= next_pc_q;
					inst_req_q <= 1'b1;
					state_q    <= FWAIT;
				end
				default: begin
					// HALT, left only by reset
					state_q <= HALT;
				end
			endcase
		end
	end

	// --------------------
	// payload capture
	// --------------------

	always_ff @(posedge clock_i) begin
		if ((state_q == FWAIT) && inst_done_i) begin
			ir_q <= inst_data_i;
		end
		if (state_q == EXEC) begin
			wb_data_q          <= exec_result;
			next_pc_q          <= next_pc;
			data_req_s_q.wren  <= is_store;
			data_req_s_q.addr  <= sum;
			data_req_s_q.wdata <= rs2_data;
		end
		// load data replaces the address result
		if ((state_q == MWAIT) && data_done_i && !data_req_s_q.wren) begin
			wb_data_q <= data_rdata_i;
		end
	end

	// register file, written in WB
	assign rf_we = (state_q == WB) && writes_rd;

	hart_regfile regfile_inst (
		.clock_i    (clock_i),
		.rst_n_i    (rst_n_i),
		.rs1_addr_i (ir_q[19:15]),
		.rs2_addr_i (ir_q[24:20]),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.we_i       (rf_we),
		.rd_addr_i  (ir_q[11:7]),
		.rd_data_i  (wb_data_q)
	);

	// outputs
	assign inst_req_o   = inst_req_q;
	assign inst_addr_o  = pc_q;
	assign data_req_o   = data_req_q;
	assign data_req_s_o = data_req_s_q;
	assign pc_o         = pc_q;
	assign inst_word_o  = ir_q;
	assign exception_o  = exc_q;

endmodule

/* design/hart_pkg.sv */
`include "hart_macros.svh"

package hart_pkg;

	// --------------------
	// data reference
	// --------------------

	// one data reference, core to switch
	// wren high for stores, low for loads
	typedef struct packed {
		logic                  wren;
		logic [`HART_XLEN-1:0] addr;
		logic [`HART_XLEN-1:0] wdata;
	} mem_req_t;

	// --------------------
	// decode
	// --------------------

	// major opcodes, bits [6:0] of the instruction word
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011
	} opcode_e;

	// bit positions within the 4-bit exception bus
	localparam int unsigned EXC_ILLEGAL = 0;

endpackage

/* design/hart_regfile.sv */
`include "hart_macros.svh"

module hart_regfile (
	input  logic                  clock_i,
	input  logic                  rst_n_i,

	// read ports
	input  logic [4:0]            rs1_addr_i,
	input  logic [4:0]            rs2_addr_i,
	output logic [`HART_XLEN-1:0] rs1_data_o,
	output logic [`HART_XLEN-1:0] rs2_data_o,

	// write port
	input  logic                  we_i,
	input  logic [4:0]            rd_addr_i,
	input  logic [`HART_XLEN-1:0] rd_data_i
);

	logic [`HART_XLEN-1:0] regs_q [32];

	// synchronous write, x0 never written
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && (rd_addr_i != 5'd0)) begin
			regs_q[rd_addr_i] <= rd_data_i;
		end
	end

	// combinational reads
	// x0 forced to zero here as well
	assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs_q[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs_q[rs2_addr_i];

endmodule

/* design/port_switch.sv */
`include "hart_macros.svh"

module port_switch (
	input  logic                  clock_i,
	input  logic                  rst_n_i,

	// core side
	input  logic                  core_req_i,
	input  hart_pkg::mem_req_t    core_req_s_i,
	output logic                  core_done_o,
	output logic [`HART_XLEN-1:0] core_data_o,

	// internal memory side
	output logic                  memory_req_o,
	output logic                  memory_wren_o,
	output logic [`HART_XLEN-1:0] memory_addr_o,
	output logic [`HART_XLEN-1:0] memory_data_o,
	input  logic                  memory_done_i,
	input  logic [`HART_XLEN-1:0] memory_data_i,

	// peripheral side, no done returned
	output logic                  peripheral_req_o,
	output logic                  peripheral_wren_o,
	output logic [`HART_XLEN-1:0] peripheral_addr_o,
	output logic [`HART_XLEN-1:0] peripheral_data_o,
	input  logic [`HART_XLEN-1:0] peripheral_data_i
);

	logic sel_per;
	logic pending_per_q;
	logic per_done_q;

	// --------------------
	// request steering
	// --------------------

	// address bit picks the side
	assign sel_per = core_req_s_i.addr[`HART_PER_SEL_BIT];

	assign memory_req_o     = core_req_i && !sel_per;
	assign peripheral_req_o = core_req_i && sel_per;

	// payload fans out to both, only the strobed side acts on it
	assign memory_wren_o     = core_req_s_i.wren;
	assign memory_addr_o     = core_req_s_i.addr;
	assign memory_data_o     = core_req_s_i.wdata;
	assign peripheral_wren_o = core_req_s_i.wren;
	assign peripheral_addr_o = core_req_s_i.addr;
	assign peripheral_data_o = core_req_s_i.wdata;

	// --------------------
	// completion
	// --------------------

	// remember the side of the outstanding reference
	// peripheral done one cycle after its strobe
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			pending_per_q <= 1'b0;
			per_done_q    <= 1'b0;
		end else begin
			per_done_q <= peripheral_req_o;
			if (core_req_i) begin
				pending_per_q <= sel_per;
			end
		end
	end

	// done and read data from the pending side
	assign core_done_o = pending_per_q ? per_done_q : memory_done_i;
	assign core_data_o = pending_per_q ? peripheral_data_i : memory_data_i;

endmodule

/* design/riscv_hart_top.sv */
`include "hart_macros.svh"

module riscv_hart_top (
	// system
	input  logic                  clock_i,
	input  logic                  rst_n_i,
	output logic [3:0]            exception_bus_o,
	output logic [`HART_XLEN-1:0] inst_addr_o,
	output logic [`HART_XLEN-1:0] inst_word_o,

	// fetch port, read only
	output logic                  mem_req0_o,
	output logic [`HART_XLEN-1:0] mem_add0_o,
	input  logic [`HART_XLEN-1:0] mem_data0_i,
	input  logic                  mem_done0_i,

	// data port to internal memory
	output logic                  mem_req1_o,
	output logic                  mem_rw1_o,
	output logic [`HART_XLEN-1:0] mem_add1_o,
	output logic [`HART_XLEN-1:0] mem_data1_o,
	input  logic [`HART_XLEN-1:0] mem_data1_i,
	input  logic                  mem_done1_i,

	// peripheral port
	output logic                  per_req_o,
	output logic                  per_rw_o,
	output logic [`HART_XLEN-1:0] per_add_o,
	output logic [`HART_XLEN-1:0] per_data_o,
	input  logic [`HART_XLEN-1:0] per_data_i
);

	// --------------------
	// core to switch
	// --------------------

	logic                  data_req;
	hart_pkg::mem_req_t    data_req_s;
	logic                  data_done;
	logic [`HART_XLEN-1:0] data_rdata;

	// hart, fetch goes straight out on port 0
	hart_core hart_inst (
		.clock_i      (clock_i),
		.rst_n_i      (rst_n_i),
		.inst_req_o   (mem_req0_o),
		.inst_addr_o  (mem_add0_o),
		.inst_data_i  (mem_data0_i),
		.inst_done_i  (mem_done0_i),
		.data_req_o   (data_req),
		.data_req_s_o (data_req_s),
		.data_rdata_i (data_rdata),
		.data_done_i  (data_done),
		.pc_o         (inst_addr_o),
		.inst_word_o  (inst_word_o),
		.exception_o  (exception_bus_o)
	);

	// data references split by address
	port_switch peripheral_switch_inst (
		.clock_i           (clock_i),
		.rst_n_i           (rst_n_i),
		.core_req_i        (data_req),
		.core_req_s_i      (data_req_s),
		.core_done_o       (data_done),
		.core_data_o       (data_rdata),
		.memory_req_o      (mem_req1_o),
		.memory_wren_o     (mem_rw1_o),
		.memory_addr_o     (mem_add1_o),
		.memory_data_o     (mem_data1_o),
		.memory_done_i     (mem_done1_i),
		.memory_data_i     (mem_data1_i),
		.peripheral_req_o  (per_req_o),
		.peripheral_wren_o (per_rw_o),
		.peripheral_addr_o (per_add_o),
		.peripheral_data_o (per_data_o),
		.peripheral_data_i (per_data_i)
	);

endmodule

/* include/hart_macros.svh */
`ifndef HART_MACROS_SVH
`define HART_MACROS_SVH

// --------------------
// datapath
// --------------------

// data and address width
`define HART_XLEN 32

// first fetch address out of reset
`define HART_RESET_PC 32'h0000_0000

// --------------------
// address map
// --------------------

// set means peripheral space, clear means internal memory
`define HART_PER_SEL_BIT 31

// test memory depth in words
`define HART_MEM_WORDS 256

`endif

/* list.f */
+incdir+include
design/hart_pkg.sv
design/hart_regfile.sv
design/hart_core.sv
design/port_switch.sv
design/riscv_hart_top.sv
tests/tb_mem_model.sv
tests/tb_riscv_hart_top.sv

/* tests/tb_mem_model.sv */
`include "hart_macros.svh"

module tb_mem_model (
	input  logic                  clock_i,

	// fetch port, read only
	input  logic                  req0_i,
	input  logic [`HART_XLEN-1:0] addr0_i,
	output logic [`HART_XLEN-1:0] data0_o,
	output logic                  done0_o,

	// data port
	input  logic                  req1_i,
	input  logic                  rw1_i,
	input  logic [`HART_XLEN-1:0] addr1_i,
	input  logic [`HART_XLEN-1:0] wdata1_i,
	output logic [`HART_XLEN-1:0] rdata1_o,
	output logic                  done1_o
);

	logic [`HART_XLEN-1:0] mem [`HART_MEM_WORDS];

	// latency state
	integer      seed       = 32'h3ae2;
	integer      wait_left  = 0;
	logic        fetch_seen = 1'b0;
	logic        fire;
	int unsigned fetch_idx;
	int unsigned data_idx;

	// byte address to word slot, wraps at memory depth
	function automatic int unsigned word_index(input logic [`HART_XLEN-1:0] addr);
		return (addr >> 2) % `HART_MEM_WORDS;
	endfunction

	initial begin
		data0_o  = '0;
		done0_o  = 1'b0;
		rdata1_o = '0;
		done1_o  = 1'b0;
		// fill tagged with the word index
		for (int i = 0; i < `HART_MEM_WORDS; i++) begin
			mem[i] = {16'ha5a5, 16'(i)};
		end
	end

	// --------------------
	// request capture
	// --------------------

	// strobes sampled mid-cycle, stores land here
	always @(negedge clock_i) begin
		fetch_seen = (req0_i === 1'b1);
		if (fetch_seen) begin
			fetch_idx = word_index(addr0_i);
		end
		if (req1_i === 1'b1) begin
			// 1 to 4 cycles until done
			wait_left = 1 + ($random(seed) & 3);
			data_idx  = word_index(addr1_i);
			if (rw1_i) begin
				mem[data_idx] = wdata1_i;
			end
		end
	end

	// --------------------
	// responses
	// --------------------

	always @(posedge clock_i) begin
		fire = 1'b0;
		if (wait_left > 0) begin
			wait_left = wait_left - 1;
			fire      = (wait_left == 0);
		end
		#1;
		// fetch done one cycle after its strobe
		done0_o  = fetch_seen;
		data0_o  = fetch_seen ? mem[fetch_idx] : '0;
		done1_o  = fire;
		rdata1_o = fire ? mem[data_idx] : '0;
	end

endmodule

/* tests/tb_riscv_hart_top.sv */
`include "hart_macros.svh"

module tb_riscv_hart_top;

	localparam int PROG_LEN       = 17;
	localparam int N_WRITES       = 5;
	localparam int N_MEM_REFS     = 2;
	localparam int TIMEOUT_CYCLES = PROG_LEN * 12 + 100;
	localparam int HALT_WINDOW    = 20;

	// program operands
	localparam logic [19:0] PER_UPPER    = 20'h80000;
	localparam logic [19:0] VAL_UPPER    = 20'h12345;
	localparam logic [11:0] VAL_LOW      = 12'h678;
	localparam logic [11:0] VAL_NEG      = 12'hffb;
	localparam logic [11:0] SCRATCH      = 12'h200;
	localparam logic [31:0] PER_RDATA    = 32'hcafe_0042;
	localparam logic [31:0] ILLEGAL_WORD = 32'h0000_000b;

	logic                  clock_i       = 1'b0;
	logic                  rst_n_i;
	logic [3:0]            exception_bus_o;
	logic [`HART_XLEN-1:0] inst_addr_o;
	logic [`HART_XLEN-1:0] inst_word_o;
	logic                  mem_req0_o;
	logic [`HART_XLEN-1:0] mem_add0_o;
	logic [`HART_XLEN-1:0] mem_data0_i;
	logic                  mem_done0_i;
	logic                  mem_req1_o;
	logic                  mem_rw1_o;
	logic [`HART_XLEN-1:0] mem_add1_o;
	logic [`HART_XLEN-1:0] mem_data1_o;
	logic [`HART_XLEN-1:0] mem_data1_i;
	logic                  mem_done1_i;
	logic                  per_req_o;
	logic                  per_rw_o;
	logic [`HART_XLEN-1:0] per_add_o;
	logic [`HART_XLEN-1:0] per_data_o;
	logic [`HART_XLEN-1:0] per_data_i    = '0;
	logic                  per_read_seen = 1'b0;

	// bookkeeping
	int errors     = 0;
	int checks     = 0;
	int per_writes = 0;
	int per_reads  = 0;
	int mem_refs   = 0;

	// program and expected peripheral writes
	logic [31:0] program_words [PROG_LEN];
	logic [31:0] exp_addr [N_WRITES];
	logic [31:0] exp_data [N_WRITES];

	// expected references on memory port 1
	logic        mem_exp_rw   [N_MEM_REFS];
	logic [31:0] mem_exp_addr [N_MEM_REFS];
	logic [31:0] mem_exp_data [N_MEM_REFS];

	initial begin
		forever #50 clock_i = ~clock_i;
	end

	riscv_hart_top dut0 (
		.clock_i         (clock_i),
		.rst_n_i         (rst_n_i),
		.exception_bus_o (exception_bus_o),
		.inst_addr_o     (inst_addr_o),
		.inst_word_o     (inst_word_o),
		.mem_req0_o      (mem_req0_o),
		.mem_add0_o      (mem_add0_o),
		.mem_data0_i     (mem_data0_i),
		.mem_done0_i     (mem_done0_i),
		.mem_req1_o      (mem_req1_o),
		.mem_rw1_o       (mem_rw1_o),
		.mem_add1_o      (mem_add1_o),
		.mem_data1_o     (mem_data1_o),
		.mem_data1_i     (mem_data1_i),
		.mem_done1_i     (mem_done1_i),
		.per_req_o       (per_req_o),
		.per_rw_o        (per_rw_o),
		.per_add_o       (per_add_o),
		.per_data_o      (per_data_o),
		.per_data_i      (per_data_i)
	);

	// ports 0 and 1 share one array
	tb_mem_model mem0 (
		.clock_i  (clock_i),
		.req0_i   (mem_req0_o),
		.addr0_i  (mem_add0_o),
		.data0_o  (mem_data0_i),
		.done0_o  (mem_done0_i),
		.req1_i   (mem_req1_o),
		.rw1_i    (mem_rw1_o),
		.addr1_i  (mem_add1_o),
		.wdata1_i (mem_data1_o),
		.rdata1_o (mem_data1_i),
		.done1_o  (mem_done1_i)
	);

	// --------------------
	// encoders
	// --------------------

	function automatic logic [31:0] sext12(input logic [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

	function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, hart_pkg::OP_LUI};
	endfunction

	// funct3 010 marks a word load
	function automatic logic [31:0] i_type(input hart_pkg::opcode_e op, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, (op == hart_pkg::OP_LOAD) ? 3'b010 : 3'b000, rd, op};
	endfunction

	function automatic logic [31:0] r_type(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2);
		return {7'b0, rs2, rs1, 3'b000, rd, hart_pkg::OP_REG};
	endfunction

	function automatic logic [31:0] s_type(input logic [4:0] rs1, input logic [4:0] rs2,
			input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], hart_pkg::OP_STORE};
	endfunction

	function automatic logic [31:0] b_type(input logic [4:0] rs1, input logic [4:0] rs2,
			input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], hart_pkg::OP_BRANCH};
	endfunction

	// x1 peripheral base, x2..x4 arithmetic, x5 memory readback, x6 peripheral read
	task automatic build_tables();
		logic [31:0] base;
		logic [31:0] x2;
		logic [31:0] x3;
		logic [31:0] x4;
		base = {PER_UPPER, 12'b0};
		x2   = {VAL_UPPER, 12'b0} + sext12(VAL_LOW);
		x3   = sext12(VAL_NEG);
		x4   = x2 + x3;
		program_words[0]  = u_type(5'd1, PER_UPPER);
		program_words[1]  = u_type(5'd2, VAL_UPPER);
		program_words[2]  = i_type(hart_pkg::OP_IMM, 5'd2, 5'd2, VAL_LOW);
		program_words[3]  = i_type(hart_pkg::OP_IMM, 5'd3, 5'd0, VAL_NEG);
		program_words[4]  = r_type(5'd4, 5'd2, 5'd3);
		program_words[5]  = s_type(5'd1, 5'd2, 12'd0);
		program_words[6]  = s_type(5'd1, 5'd4, 12'd4);
		// round trip through internal memory
		program_words[7]  = s_type(5'd0, 5'd4, SCRATCH);
		program_words[8]  = i_type(hart_pkg::OP_LOAD, 5'd5, 5'd0, SCRATCH);
		program_words[9]  = s_type(5'd1, 5'd5, 12'd8);
		program_words[10] = i_type(hart_pkg::OP_LOAD, 5'd6, 5'd1, 12'd12);
		program_words[11] = s_type(5'd1, 5'd6, 12'd16);
		// taken beq skips word 13 and the not-taken one falls into word 15
		program_words[12] = b_type(5'd2, 5'd2, 13'd8);
		program_words[13] = s_type(5'd1, 5'd2, 12'd20);
		program_words[14] = b_type(5'd2, 5'd4, 13'd8);
		program_words[15] = s_type(5'd1, 5'd3, 12'd24);
		program_words[16] = ILLEGAL_WORD;
		exp_addr[0] = base;
		exp_data[0] = x2;
		exp_addr[1] = base + 32'd4;
		exp_data[1] = x4;
		exp_addr[2] = base + 32'd8;
		exp_data[2] = x4;
		exp_addr[3] = base + 32'd16;
		exp_data[3] = PER_RDATA;
		exp_addr[4] = base + 32'd24;
		exp_data[4] = x3;
		// store then load of the scratch word
		mem_exp_rw[0]   = 1'b1;
		mem_exp_addr[0] = sext12(SCRATCH);
		mem_exp_data[0] = x4;
		mem_exp_rw[1]   = 1'b0;
		mem_exp_addr[1] = sext12(SCRATCH);
		mem_exp_data[1] = '0;
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// --------------------
	// peripheral model
	// --------------------

	always @(negedge clock_i) begin
		per_read_seen = (per_req_o === 1'b1) && (per_rw_o === 1'b0);
		if (per_req_o === 1'b1) begin
			if (per_add_o[`HART_PER_SEL_BIT] !== 1'b1) begin
				errors++;
				$display("ERROR at %0t: peripheral strobe for memory address %h",
					$time, per_add_o);
			end
			if (per_rw_o) begin
				per_writes++;
			end else begin
				per_reads++;
			end
		end
	end

	// read data valid in the switch's done cycle
	always @(posedge clock_i) begin
		#1;
		per_data_i = per_read_seen ? PER_RDATA : '0;
	end

	// --------------------
	// memory port monitor
	// --------------------

	// port 1 references in program order
	always @(negedge clock_i) begin
		if (mem_req1_o === 1'b1) begin
			if (mem_refs < N_MEM_REFS) begin
				compare_value("mem_rw1_o", 32'(mem_exp_rw[mem_refs]), 32'(mem_rw1_o));
				compare_value("mem_add1_o", mem_exp_addr[mem_refs], mem_add1_o);
				if (mem_exp_rw[mem_refs]) begin
					compare_value("mem_data1_o", mem_exp_data[mem_refs], mem_data1_o);
				end
			end
			mem_refs++;
		end
	end

	// --------------------
	// sequence
	// --------------------

	initial begin
		int fetches_after;
		rst_n_i = 1'b0;
		build_tables();
		@(posedge clock_i);
		// load while reset is held
		for (int i = 0; i < PROG_LEN; i++) begin
			mem0.mem[i] = program_words[i];
		end
		repeat (7) @(posedge clock_i);
		#1 rst_n_i = 1'b1;

		// first fetch out of reset
		@(negedge clock_i);
		while (mem_req0_o !== 1'b1) begin
			@(negedge clock_i);
		end
		compare_value("mem_add0_o", `HART_RESET_PC, mem_add0_o);
		compare_value("exception_bus_o", 32'd0, 32'(exception_bus_o));

		// peripheral writes in program order
		for (int w = 0; w < N_WRITES; w++) begin
			@(negedge clock_i);
			while (!((per_req_o === 1'b1) && (per_rw_o === 1'b1))) begin
				@(negedge clock_i);
			end
			compare_value("per_add_o", exp_addr[w], per_add_o);
			compare_value("per_data_o", exp_data[w], per_data_o);
		end

		// illegal word halts the hart
		while (exception_bus_o[hart_pkg::EXC_ILLEGAL] !== 1'b1) begin
			@(negedge clock_i);
		end
		compare_value("exception_bus_o", 32'd1 << hart_pkg::EXC_ILLEGAL, 32'(exception_bus_o));
		compare_value("inst_addr_o", (PROG_LEN - 1) * 4, inst_addr_o);
		compare_value("inst_word_o", ILLEGAL_WORD, inst_word_o);
		fetches_after = 0;
		repeat (HALT_WINDOW) begin
			@(negedge clock_i);
			if (mem_req0_o === 1'b1) begin
				fetches_after++;
			end
		end
		compare_value("mem_req0_o strobes after halt", 32'd0, fetches_after);
		compare_value("peripheral write count", N_WRITES, per_writes);
		compare_value("peripheral read count", 32'd1, per_reads);
		compare_value("memory reference count", N_MEM_REFS, mem_refs);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clock_i);
		$display("run timed out after %0d cycles, errors: %0d", TIMEOUT_CYCLES, errors);
		$display("Regression failed");
		$finish;
	end

endmodule
